// File: files.f
+incdir+.
pic_cmd_pkg.sv
pic_ctrl_pkg.sv
init_sequencer.sv
operation_regs.sv
ack_sequencer.sv
pic_control.sv
tb_pic_control.sv

// File: tb_pic_checks.svh
`ifndef TB_PIC_CHECKS_SVH
`define TB_PIC_CHECKS_SVH

// what one table row does to the pins
typedef enum logic [3:0] {
	act_idle,
	act_icw1,
	act_icw2_4,
	act_ocw1,
	act_ocw2,
	act_ocw3,
	act_inta_low,
	act_inta_high,
	act_read_low,
	act_read_high
} action_e;

// outputs compared by a row
typedef struct packed {
	logic int_req;
	logic freeze;
	logic vector;
	logic mask;
	logic eoi;
	logic rotate;
	logic read_sel;
	logic clear;
	logic ltim;
} check_sel_t;

typedef struct packed {
	action_e                  act;
	logic [7:0]               data;
	pic_ctrl_pkg::level_t     irq;
	pic_ctrl_pkg::level_t     isr;
	check_sel_t               sel;
	logic                     exp_int;
	logic                     exp_freeze;
	logic                     exp_doe;
	logic [7:0]               exp_dout;
	pic_ctrl_pkg::level_t     exp_mask;
	pic_ctrl_pkg::level_t     exp_eoi;
	pic_ctrl_pkg::level_num_t exp_rot;
	logic                     exp_ren;
	logic                     exp_risr;
	logic                     exp_ltim;
	pic_ctrl_pkg::level_t     exp_clr;
} row_t;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic stop_on_error();
	fail_count = fail_count + 1;
	$display("Test failed");
	$fatal(1);
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		stop_on_error();
	end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		stop_on_error();
	end
endtask

task automatic check_level(input string name, input pic_ctrl_pkg::level_t got,
		input pic_ctrl_pkg::level_t exp);
	if (got !== exp) begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		stop_on_error();
	end
endtask

task automatic check_num(input string name, input pic_ctrl_pkg::level_num_t got,
		input pic_ctrl_pkg::level_num_t exp);
	if (got !== exp) begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		stop_on_error();
	end
endtask

`endif

// File: tb_pic_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pic_control;

	localparam int reset_cycles = 8;
	localparam int max_rows = 64;

	logic                         clk;
	logic                         rst_n;
	pic_cmd_pkg::cmd_strobes_t    strobes;
	logic [7:0]                   data_bus;
	logic                         inta;
	logic                         read;
	pic_ctrl_pkg::level_t         interrupt;
	pic_ctrl_pkg::level_t         highest_level_in_service;
	logic                         int_req;
	logic                         data_out_en;
	logic [7:0]                   data_out;
	pic_ctrl_pkg::level_t         interrupt_mask;
	pic_ctrl_pkg::level_t         end_interrupt;
	pic_ctrl_pkg::level_num_t     priority_rotate;
	logic                         read_enable;
	logic                         read_isr;
	logic                         ltim;
	logic                         freeze;
	pic_ctrl_pkg::level_t         clear_interrupt_request;

	int                           fail_count;

	`include "tb_pic_checks.svh"

	logic                         table_ready;
	logic [31:0]                  rng;
	row_t                         rows [max_rows];
	int                           n_rows;
	pic_ctrl_pkg::level_t         irq_v;
	pic_ctrl_pkg::level_t         isr_v;

	pic_control u_pic_control (
		.clk                      (clk),
		.rst_n                    (rst_n),
		.strobes                  (strobes),
		.data_bus                 (data_bus),
		.inta                     (inta),
		.read                     (read),
		.interrupt                (interrupt),
		.highest_level_in_service (highest_level_in_service),
		.int_req                  (int_req),
		.data_out_en              (data_out_en),
		.data_out                 (data_out),
		.interrupt_mask           (interrupt_mask),
		.end_interrupt            (end_interrupt),
		.priority_rotate          (priority_rotate),
		.read_enable              (read_enable),
		.read_isr                 (read_isr),
		.ltim                     (ltim),
		.freeze                   (freeze),
		.clear_interrupt_request  (clear_interrupt_request)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic draw_random(output logic [7:0] value);
		rng = lcg_next(rng);
		value = rng[23:16];
	endtask

	// new row with the current request and in-service levels, nothing checked yet
	task automatic add_row(input action_e act, input logic [7:0] data);
		row_t row;
		row = '0;
		row.act = act;
		row.data = data;
		row.irq = irq_v;
		row.isr = isr_v;
		rows[n_rows] = row;
		n_rows++;
	endtask

	task automatic int_is(input logic v);
		rows[n_rows - 1].sel.int_req = 1'b1;
		rows[n_rows - 1].exp_int = v;
	endtask

	task automatic freeze_is(input logic v);
		rows[n_rows - 1].sel.freeze = 1'b1;
		rows[n_rows - 1].exp_freeze = v;
	endtask

	task automatic vector_is(input logic en, input logic [7:0] v);
		rows[n_rows - 1].sel.vector = 1'b1;
		rows[n_rows - 1].exp_doe = en;
		rows[n_rows - 1].exp_dout = v;
	endtask

	task automatic mask_is(input pic_ctrl_pkg::level_t v);
		rows[n_rows - 1].sel.mask = 1'b1;
		rows[n_rows - 1].exp_mask = v;
	endtask

	task automatic eoi_is(input pic_ctrl_pkg::level_t v);
		rows[n_rows - 1].sel.eoi = 1'b1;
		rows[n_rows - 1].exp_eoi = v;
	endtask

	task automatic rotate_is(input pic_ctrl_pkg::level_num_t v);
		rows[n_rows - 1].sel.rotate = 1'b1;
		rows[n_rows - 1].exp_rot = v;
	endtask

	task automatic read_sel_is(input logic ren, input logic risr);
		rows[n_rows - 1].sel.read_sel = 1'b1;
		rows[n_rows - 1].exp_ren = ren;
		rows[n_rows - 1].exp_risr = risr;
	endtask

	task automatic ltim_is(input logic v);
		rows[n_rows - 1].sel.ltim = 1'b1;
		rows[n_rows - 1].exp_ltim = v;
	endtask

	task automatic clear_is(input pic_ctrl_pkg::level_t v);
		rows[n_rows - 1].sel.clear = 1'b1;
		rows[n_rows - 1].exp_clr = v;
	endtask

	// state after reset or ICW1
	task automatic defaults_are();
		mask_is(8'hff);
		rotate_is(3'd7);
		read_sel_is(1'b1, 1'b0);
		int_is(1'b0);
		freeze_is(1'b0);
		vector_is(1'b0, 8'h00);
		eoi_is(8'h00);
	endtask

	// registered results of a row show up in the next row
	task automatic build_table();
		logic [7:0] icw2_a;
		logic [7:0] icw2_b;
		logic [7:0] mask_a;
		logic [7:0] mask_b;
		logic [7:0] r;
		logic [2:0] p1;
		logic [2:0] n2;
		logic [2:0] p3;
		logic [2:0] l_ack;
		logic [2:0] l_poll;
		logic [2:0] l_aeoi;
		draw_random(icw2_a);
		draw_random(icw2_b);
		draw_random(mask_a);
		mask_a = mask_a & 8'h7f;
		draw_random(mask_b);
		mask_b = mask_b & 8'hfe;
		draw_random(r);
		p1 = r[2:0];
		n2 = p1 ^ 3'b100;
		draw_random(r);
		p3 = r[2:0];
		draw_random(r);
		l_ack = r[2:0];
		draw_random(r);
		l_poll = r[2:0];
		draw_random(r);
		// must differ from the reset rotation of 7
		l_aeoi = (r[2:0] == 3'd7) ? 3'd3 : r[2:0];
		n_rows = 0;
		irq_v = '0;
		isr_v = '0;

		add_row(act_idle, 8'h00);
		defaults_are();
		ltim_is(1'b0);
		clear_is(8'h00);

		// single mode, level triggered, no ICW4
		add_row(act_icw1, 8'h1a);
		clear_is(8'hff);
		add_row(act_icw2_4, icw2_a);
		int_is(1'b0);
		ltim_is(1'b1);
		add_row(act_ocw1, mask_a);
		mask_is(8'hff);
		add_row(act_idle, 8'h00);
		mask_is(mask_a);

		add_row(act_ocw3, 8'h0b);
		add_row(act_ocw3, 8'h08);
		read_sel_is(1'b1, 1'b1);
		add_row(act_idle, 8'h00);
		read_sel_is(1'b0, 1'b0);

		// EOI and rotation commands
		isr_v = 8'd1 << n2;
		add_row(act_ocw2, {pic_cmd_pkg::op_set_priority, 2'b00, p1});
		add_row(act_ocw2, {pic_cmd_pkg::op_nonspecific_eoi, 5'b00000});
		rotate_is(p1);
		add_row(act_ocw2, {pic_cmd_pkg::op_rotate_nonspecific_eoi, 5'b00000});
		eoi_is(isr_v);
		rotate_is(p1);
		add_row(act_ocw2, {pic_cmd_pkg::op_specific_eoi, 2'b00, p3});
		eoi_is(isr_v);
		rotate_is(n2);
		add_row(act_idle, 8'h00);
		eoi_is(8'd1 << p3);
		rotate_is(n2);
		add_row(act_idle, 8'h00);
		eoi_is(8'h00);

		// two-pulse acknowledge
		irq_v = 8'd1 << l_ack;
		isr_v = 8'd1 << l_ack;
		add_row(act_idle, 8'h00);
		int_is(1'b0);
		add_row(act_idle, 8'h00);
		int_is(1'b1);
		add_row(act_inta_low, 8'h00);
		freeze_is(1'b0);
		clear_is(irq_v);
		add_row(act_idle, 8'h00);
		freeze_is(1'b1);
		clear_is(8'h00);
		vector_is(1'b0, 8'h00);
		add_row(act_inta_high, 8'h00);
		vector_is(1'b0, 8'h00);
		add_row(act_inta_low, 8'h00);
		vector_is(1'b1, {icw2_a[7:3], l_ack});
		irq_v = '0;
		add_row(act_idle, 8'h00);
		vector_is(1'b1, {icw2_a[7:3], l_ack});
		int_is(1'b1);
		add_row(act_inta_high, 8'h00);
		vector_is(1'b0, 8'h00);
		freeze_is(1'b1);
		add_row(act_idle, 8'h00);
		int_is(1'b0);
		freeze_is(1'b0);
		eoi_is(8'h00);

		// poll command, ended by a read
		irq_v = 8'd1 << l_poll;
		isr_v = 8'd1 << l_poll;
		add_row(act_idle, 8'h00);
		irq_v = '0;
		add_row(act_ocw3, 8'h0c);
		int_is(1'b1);
		freeze_is(1'b0);
		add_row(act_idle, 8'h00);
		freeze_is(1'b1);
		int_is(1'b1);
		add_row(act_read_low, 8'h00);
		freeze_is(1'b1);
		add_row(act_idle, 8'h00);
		freeze_is(1'b0);
		int_is(1'b0);
		add_row(act_read_high, 8'h00);
		freeze_is(1'b0);

		// pending request that the next ICW1 must drop
		irq_v = 8'd1 << l_poll;
		add_row(act_idle, 8'h00);
		irq_v = '0;

		// cascade mode with ICW4 and AEOI
		add_row(act_icw1, 8'h11);
		clear_is(8'hff);
		int_is(1'b1);
		add_row(act_idle, 8'h00);
		defaults_are();
		ltim_is(1'b0);
		add_row(act_icw2_4, icw2_b);
		add_row(act_ocw1, mask_b);
		add_row(act_icw2_4, 8'h00);
		mask_is(8'hff);
		add_row(act_icw2_4, 8'h03);
		add_row(act_ocw1, mask_b);
		mask_is(8'hff);
		add_row(act_idle, 8'h00);
		mask_is(mask_b);

		// automatic EOI with auto-rotate
		add_row(act_ocw2, {pic_cmd_pkg::op_rotate_aeoi_set, 5'b00000});
		irq_v = 8'd1 << l_aeoi;
		isr_v = 8'd1 << l_aeoi;
		add_row(act_idle, 8'h00);
		eoi_is(8'h00);
		add_row(act_inta_low, 8'h00);
		int_is(1'b1);
		clear_is(irq_v);
		add_row(act_inta_high, 8'h00);
		freeze_is(1'b1);
		add_row(act_inta_low, 8'h00);
		vector_is(1'b1, {icw2_b[7:3], l_aeoi});
		irq_v = '0;
		add_row(act_inta_high, 8'h00);
		eoi_is(8'h00);
		rotate_is(3'd7);
		add_row(act_idle, 8'h00);
		eoi_is(8'd1 << l_aeoi);
		rotate_is(l_aeoi);
		freeze_is(1'b0);
		int_is(1'b0);
		add_row(act_idle, 8'h00);
		eoi_is(8'h00);
	endtask

	// inta and read keep their level until a row changes them
	task automatic drive_row(input row_t row);
		strobes = '0;
		data_bus = row.data;
		interrupt = row.irq;
		highest_level_in_service = row.isr;
		case (row.act)
			act_icw1:      strobes.write_icw1 = 1'b1;
			act_icw2_4:    strobes.write_icw2_4 = 1'b1;
			act_ocw1:      strobes.write_ocw1 = 1'b1;
			act_ocw2:      strobes.write_ocw2 = 1'b1;
			act_ocw3:      strobes.write_ocw3 = 1'b1;
			act_inta_low:  inta = 1'b0;
			act_inta_high: inta = 1'b1;
			act_read_low:  read = 1'b0;
			act_read_high: read = 1'b1;
			default:       strobes = '0;
		endcase
	endtask

	task automatic check_row(input row_t row);
		if (row.sel.int_req) begin
			check_bit("int_req", int_req, row.exp_int);
		end
		if (row.sel.freeze) begin
			check_bit("freeze", freeze, row.exp_freeze);
		end
		if (row.sel.vector) begin
			check_bit("data_out_en", data_out_en, row.exp_doe);
			check_byte("data_out", data_out, row.exp_dout);
		end
		if (row.sel.mask) begin
			check_level("interrupt_mask", interrupt_mask, row.exp_mask);
		end
		if (row.sel.eoi) begin
			check_level("end_interrupt", end_interrupt, row.exp_eoi);
		end
		if (row.sel.rotate) begin
			check_num("priority_rotate", priority_rotate, row.exp_rot);
		end
		if (row.sel.read_sel) begin
			check_bit("read_enable", read_enable, row.exp_ren);
			check_bit("read_isr", read_isr, row.exp_risr);
		end
		if (row.sel.ltim) begin
			check_bit("ltim", ltim, row.exp_ltim);
		end
		if (row.sel.clear) begin
			check_level("clear_interrupt_request", clear_interrupt_request, row.exp_clr);
		end
	endtask

	initial begin
		wait (table_ready === 1'b1);
		repeat (reset_cycles + n_rows * 20) @(posedge clk);
		$display("timeout: the stimulus table did not finish in time");
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		fail_count = 0;
		table_ready = 1'b0;
		rst_n = 1'b0;
		strobes = '0;
		data_bus = 8'h00;
		inta = 1'b1;
		read = 1'b1;
		interrupt = '0;
		highest_level_in_service = '0;
		rng = 32'h3beb;
		build_table();
		table_ready = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// drive after the edge, compare at the falling edge
		for (int i = 0; i < n_rows; i++) begin
			@(posedge clk);
			#1;
			drive_row(rows[i]);
			@(negedge clk);
			check_row(rows[i]);
		end
		@(posedge clk);
		if (fail_count == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: pic_control.sv
`timescale 1ns/1ps
`default_nettype none

module pic_control (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire pic_cmd_pkg::cmd_strobes_t   strobes,
	input  wire [7:0]                   data_bus,
	input  wire                         inta,
	input  wire                         read,
	input  wire pic_ctrl_pkg::level_t        interrupt,
	input  wire pic_ctrl_pkg::level_t        highest_level_in_service,
	output logic                        int_req,
	output logic                        data_out_en,
	output logic [7:0]                  data_out,
	output pic_ctrl_pkg::level_t        interrupt_mask,
	output pic_ctrl_pkg::level_t        end_interrupt,
	output pic_ctrl_pkg::level_num_t    priority_rotate,
	output logic                        read_enable,
	output logic                        read_isr,
	output logic                        ltim,
	output logic                        freeze,
	output pic_ctrl_pkg::level_t        clear_interrupt_request
);

	pic_ctrl_pkg::init_cfg_t   cfg;
	pic_ctrl_pkg::ack_events_t events;
	logic                      poll_cmd;

	init_sequencer u_init_sequencer (
		.clk      (clk),
		.rst_n    (rst_n),
		.strobes  (strobes),
		.data_bus (data_bus),
		.cfg      (cfg)
	);

	operation_regs u_operation_regs (
		.clk                      (clk),
		.rst_n                    (rst_n),
		.strobes                  (strobes),
		.data_bus                 (data_bus),
		.cfg                      (cfg),
		.events                   (events),
		.highest_level_in_service (highest_level_in_service),
		.interrupt_mask           (interrupt_mask),
		.end_interrupt            (end_interrupt),
		.priority_rotate          (priority_rotate),
		.read_enable              (read_enable),
		.read_isr                 (read_isr),
		.poll_cmd                 (poll_cmd)
	);

	ack_sequencer u_ack_sequencer (
		.clk                      (clk),
		.rst_n                    (rst_n),
		.write_icw1               (strobes.write_icw1),
		.inta                     (inta),
		.read                     (read),
		.poll_cmd                 (poll_cmd),
		.cfg                      (cfg),
		.interrupt                (interrupt),
		.highest_level_in_service (highest_level_in_service),
		.events                   (events),
		.int_req                  (int_req),
		.freeze                   (freeze),
		.clear_interrupt_request  (clear_interrupt_request),
		.data_out_en              (data_out_en),
		.data_out                 (data_out)
	);

	// level or edge trigger select for the request register
	assign ltim = cfg.ltim;

endmodule

`default_nettype wire

// File: ack_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ack_sequencer (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        write_icw1,
	input  wire                        inta,
	input  wire                        read,
	input  wire                        poll_cmd,
	input  wire pic_ctrl_pkg::init_cfg_t    cfg,
	input  wire pic_ctrl_pkg::level_t       interrupt,
	input  wire pic_ctrl_pkg::level_t       highest_level_in_service,
	output pic_ctrl_pkg::ack_events_t  events,
	output logic                       int_req,
	output logic                       freeze,
	output pic_ctrl_pkg::level_t       clear_interrupt_request,
	output logic                       data_out_en,
	output logic [7:0]                 data_out
);

	logic                     inta_q;
	logic                     read_q;
	logic                     inta_fall;
	logic                     inta_rise;
	logic                     read_fall;
	logic                     latch_isr;
	logic                     ack_end;
	logic                     poll_end;
	pic_ctrl_pkg::ack_state_e state;
	pic_ctrl_pkg::ack_state_e fsm_next;
	pic_ctrl_pkg::ack_state_e state_next;
	pic_ctrl_pkg::level_t     acked_level;

	// previous pin levels for edge detect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inta_q <= 1'b1;
			read_q <= 1'b1;
		end else begin
			inta_q <= inta;
			read_q <= read;
		end
	end

	assign inta_fall = inta_q & ~inta;
	assign inta_rise = ~inta_q & inta;
	assign read_fall = read_q & ~read;

	always_comb begin
		fsm_next = state;
		case (state)
			pic_ctrl_pkg::ack_idle: begin
				if (poll_cmd) begin
					fsm_next = pic_ctrl_pkg::ack_poll;
				end else if (inta_fall) begin
					fsm_next = pic_ctrl_pkg::ack_first;
				end
			end
			pic_ctrl_pkg::ack_first: begin
				if (inta_rise) begin
					fsm_next = pic_ctrl_pkg::ack_second;
				end
			end
			pic_ctrl_pkg::ack_second: begin
				if (inta_rise) begin
					fsm_next = pic_ctrl_pkg::ack_idle;
				end
			end
			default: begin
				if (read_fall) begin
					fsm_next = pic_ctrl_pkg::ack_idle;
				end
			end
		endcase
	end

	// ICW1 aborts any sequence in flight
	assign state_next = write_icw1 ? pic_ctrl_pkg::ack_idle : fsm_next;

	assign latch_isr = ~write_icw1 & (state == pic_ctrl_pkg::ack_idle) &
		(fsm_next != pic_ctrl_pkg::ack_idle);
	assign ack_end = ~write_icw1 & (state == pic_ctrl_pkg::ack_second) &
		(fsm_next == pic_ctrl_pkg::ack_idle);
	assign poll_end = ~write_icw1 & (state == pic_ctrl_pkg::ack_poll) &
		(fsm_next == pic_ctrl_pkg::ack_idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= pic_ctrl_pkg::ack_idle;
			freeze <= 1'b0;
		end else begin
			state  <= state_next;
			freeze <= (state_next != pic_ctrl_pkg::ack_idle);
		end
	end

	// level taken into service for this acknowledge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acked_level <= '0;
		end else if (write_icw1 || ack_end || poll_end) begin
			acked_level <= '0;
		end else if (latch_isr) begin
			acked_level <= highest_level_in_service;
		end
	end

	// INT to the CPU
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			int_req <= 1'b0;
		end else if (write_icw1) begin
			int_req <= 1'b0;
		end else if (interrupt != '0) begin
			int_req <= 1'b1;
		end else if (ack_end || poll_end) begin
			int_req <= 1'b0;
		end
	end

	always_comb begin
		if (write_icw1) begin
			clear_interrupt_request = '1;
		end else if (latch_isr) begin
			clear_interrupt_request = interrupt;
		end else begin
			clear_interrupt_request = '0;
		end
	end

	// 8086 vector on the second INTA pulse
	assign data_out_en = (state == pic_ctrl_pkg::ack_second) & ~inta;
	assign data_out = data_out_en ?
		{cfg.vector_base, pic_ctrl_pkg::level_to_num(acked_level)} : 8'h00;

	assign events.latch_isr   = latch_isr;
	assign events.ack_end     = ack_end;
	assign events.poll_end    = poll_end;
	assign events.acked_level = acked_level;

endmodule

`default_nettype wire

// File: operation_regs.sv
`timescale 1ns/1ps
`default_nettype none

module operation_regs (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire pic_cmd_pkg::cmd_strobes_t   strobes,
	input  wire [7:0]                   data_bus,
	input  wire pic_ctrl_pkg::init_cfg_t     cfg,
	input  wire pic_ctrl_pkg::ack_events_t   events,
	input  wire pic_ctrl_pkg::level_t        highest_level_in_service,
	output pic_ctrl_pkg::level_t        interrupt_mask,
	output pic_ctrl_pkg::level_t        end_interrupt,
	output pic_ctrl_pkg::level_num_t    priority_rotate,
	output logic                        read_enable,
	output logic                        read_isr,
	output logic                        poll_cmd
);

	logic                  ocw1_wr;
	logic                  ocw2_wr;
	logic                  ocw3_wr;
	logic                  auto_rotate;
	pic_cmd_pkg::ocw2_op_e ocw2_op;
	pic_ctrl_pkg::level_t  eoi_mask;

	// OCWs count only once init is done
	assign ocw1_wr = strobes.write_ocw1 & cfg.operational;
	assign ocw2_wr = strobes.write_ocw2 & cfg.operational;
	assign ocw3_wr = strobes.write_ocw3 & cfg.operational;

	assign ocw2_op = pic_cmd_pkg::ocw2_op_e'(data_bus[7:5]);

	// EOI mask from the opcode
	always_comb begin
		case (ocw2_op)
			pic_cmd_pkg::op_nonspecific_eoi,
			pic_cmd_pkg::op_rotate_nonspecific_eoi: begin
				eoi_mask = highest_level_in_service;
			end
			pic_cmd_pkg::op_specific_eoi,
			pic_cmd_pkg::op_rotate_specific_eoi: begin
				eoi_mask = pic_ctrl_pkg::num_to_level(data_bus[2:0]);
			end
			default: begin
				eoi_mask = '0;
			end
		endcase
	end

	// OCW1 mask
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			interrupt_mask <= '1;
		end else if (strobes.write_icw1) begin
			interrupt_mask <= '1;
		end else if (ocw1_wr) begin
			interrupt_mask <= data_bus;
		end
	end

	// one-cycle EOI pulse, AEOI takes precedence over a written OCW2
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			end_interrupt <= '0;
		end else if (strobes.write_icw1) begin
			end_interrupt <= '0;
		end else if (cfg.aeoi && events.ack_end) begin
			end_interrupt <= events.acked_level;
		end else if (ocw2_wr) begin
			end_interrupt <= eoi_mask;
		end else begin
			end_interrupt <= '0;
		end
	end

	// rotate in AEOI mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			auto_rotate <= 1'b0;
		end else if (strobes.write_icw1) begin
			auto_rotate <= 1'b0;
		end else if (ocw2_wr) begin
			if (ocw2_op == pic_cmd_pkg::op_rotate_aeoi_set) begin
				auto_rotate <= 1'b1;
			end else if (ocw2_op == pic_cmd_pkg::op_rotate_aeoi_clear) begin
				auto_rotate <= 1'b0;
			end
		end
	end

	// lowest priority level number
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			priority_rotate <= 3'd7;
		end else if (strobes.write_icw1) begin
			priority_rotate <= 3'd7;
		end else if (auto_rotate && events.ack_end) begin
			priority_rotate <= pic_ctrl_pkg::level_to_num(events.acked_level);
		end else if (ocw2_wr) begin
			case (ocw2_op)
				pic_cmd_pkg::op_rotate_nonspecific_eoi: begin
					priority_rotate <= pic_ctrl_pkg::level_to_num(highest_level_in_service);
				end
				pic_cmd_pkg::op_set_priority,
				pic_cmd_pkg::op_rotate_specific_eoi: begin
					priority_rotate <= data_bus[2:0];
				end
				default: begin
					priority_rotate <= priority_rotate;
				end
			endcase
		end
	end

	// OCW3 register read select
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_enable <= 1'b1;
			read_isr    <= 1'b0;
		end else if (strobes.write_icw1) begin
			read_enable <= 1'b1;
			read_isr    <= 1'b0;
		end else if (ocw3_wr) begin
			read_enable <= data_bus[pic_cmd_pkg::OCW3_RR_BIT];
			read_isr    <= data_bus[pic_cmd_pkg::OCW3_RIS_BIT];
		end
	end

	assign poll_cmd = ocw3_wr & data_bus[pic_cmd_pkg::OCW3_P_BIT];

endmodule

`default_nettype wire

// File: init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module init_sequencer (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire pic_cmd_pkg::cmd_strobes_t strobes,
	input  wire [7:0]                 data_bus,
	output pic_ctrl_pkg::init_cfg_t   cfg
);

	pic_cmd_pkg::init_step_e step;
	logic                    single_mode;
	logic                    icw4_needed;
	logic                    ltim;
	logic                    aeoi;
	logic [4:0]              vector_base;

	// step machine for ICW2..ICW4
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= pic_cmd_pkg::step_ready;
		end else if (strobes.write_icw1) begin
			step <= pic_cmd_pkg::step_icw2;
		end else if (strobes.write_icw2_4) begin
			case (step)
				pic_cmd_pkg::step_icw2: begin
					if (!single_mode) begin
						step <= pic_cmd_pkg::step_icw3;
					end else if (icw4_needed) begin
						step <= pic_cmd_pkg::step_icw4;
					end else begin
						step <= pic_cmd_pkg::step_ready;
					end
				end
				// slave map is dropped, the byte only moves the step on
				pic_cmd_pkg::step_icw3: begin
					if (icw4_needed) begin
						step <= pic_cmd_pkg::step_icw4;
					end else begin
						step <= pic_cmd_pkg::step_ready;
					end
				end
				default: begin
					step <= pic_cmd_pkg::step_ready;
				end
			endcase
		end
	end

	// ICW1 flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			single_mode <= 1'b1;
			icw4_needed <= 1'b0;
			ltim        <= 1'b0;
		end else if (strobes.write_icw1) begin
			single_mode <= data_bus[pic_cmd_pkg::ICW1_SNGL_BIT];
			icw4_needed <= data_bus[pic_cmd_pkg::ICW1_IC4_BIT];
			ltim        <= data_bus[pic_cmd_pkg::ICW1_LTIM_BIT];
		end
	end

	// vector base from ICW2, AEOI from ICW4
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vector_base <= '0;
			aeoi        <= 1'b0;
		end else if (strobes.write_icw1) begin
			vector_base <= '0;
			aeoi        <= 1'b0;
		end else if (strobes.write_icw2_4) begin
			if (step == pic_cmd_pkg::step_icw2) begin
				vector_base <= data_bus[7:pic_cmd_pkg::VECTOR_BASE_LSB];
			end
			if (step == pic_cmd_pkg::step_icw4) begin
				aeoi <= data_bus[pic_cmd_pkg::ICW4_AEOI_BIT];
			end
		end
	end

	assign cfg.vector_base = vector_base;
	assign cfg.ltim        = ltim;
	assign cfg.aeoi        = aeoi;
	assign cfg.operational = (step == pic_cmd_pkg::step_ready);

endmodule

`default_nettype wire

// File: pic_ctrl_pkg.sv
`default_nettype none

package pic_ctrl_pkg;

	typedef logic [7:0] level_t;
	typedef logic [2:0] level_num_t;

	// acknowledge / poll sequence
	typedef enum logic [1:0] {
		ack_idle   = 2'b00,
		ack_first  = 2'b01,
		ack_second = 2'b10,
		ack_poll   = 2'b11
	} ack_state_e;

	// settings captured by the init words
	typedef struct packed {
		logic [4:0] vector_base;
		logic       ltim;
		logic       aeoi;
		logic       operational;
	} init_cfg_t;

	// acknowledge sequencer events, each one cycle wide
	typedef struct packed {
		logic   latch_isr;
		logic   ack_end;
		logic   poll_end;
		level_t acked_level;
	} ack_events_t;

	// highest set bit wins, zero gives level 0
	function automatic level_num_t level_to_num(input level_t level);
		level_num_t num;
		num = '0;
		for (int i = 0; i < 8; i++) begin
			if (level[i]) begin
				num = level_num_t'(i);
			end
		end
		return num;
	endfunction

	function automatic level_t num_to_level(input level_num_t num);
		return level_t'(8'd1 << num);
	endfunction

endpackage

`default_nettype wire

// File: pic_cmd_pkg.sv
`default_nettype none

package pic_cmd_pkg;

	// decoded write pulses from the bus interface
	typedef struct packed {
		logic write_icw1;
		logic write_icw2_4;
		logic write_ocw1;
		logic write_ocw2;
		logic write_ocw3;
	} cmd_strobes_t;

	// which ICW the next icw2_4 write is taken as
	typedef enum logic [1:0] {
		step_ready = 2'b00,
		step_icw2  = 2'b01,
		step_icw3  = 2'b10,
		step_icw4  = 2'b11
	} init_step_e;

	// OCW2 bits 7..5 (R, SL, EOI)
	typedef enum logic [2:0] {
		op_rotate_aeoi_clear      = 3'b000,
		op_nonspecific_eoi        = 3'b001,
		op_nop                    = 3'b010,
		op_specific_eoi           = 3'b011,
		op_rotate_aeoi_set        = 3'b100,
		op_rotate_nonspecific_eoi = 3'b101,
		op_set_priority           = 3'b110,
		op_rotate_specific_eoi    = 3'b111
	} ocw2_op_e;

	// ICW1 fields
	localparam int unsigned ICW1_IC4_BIT  = 0;
	localparam int unsigned ICW1_SNGL_BIT = 1;
	localparam int unsigned ICW1_LTIM_BIT = 3;

	// ICW4 fields
	localparam int unsigned ICW4_AEOI_BIT = 1;

	// OCW3 fields
	localparam int unsigned OCW3_RIS_BIT = 0;
	localparam int unsigned OCW3_RR_BIT  = 1;
	localparam int unsigned OCW3_P_BIT   = 2;

	// 8086 vector takes T7..T3 from ICW2
	localparam int unsigned VECTOR_BASE_LSB = 3;

endpackage

`default_nettype wire
